/* Bender.yml */
package:
  name: ex_unit

sources:
  - files:
      - hw/ex_op_pkg.sv
      - hw/ex_ctrl_pkg.sv
      - hw/mul_if.sv
      - hw/alu_core.sv
      - hw/mul_ctrl.sv
      - hw/mul_counter.sv
      - hw/mul_datapath.sv
      - hw/ex_unit.sv
  - target: test
    files:
      - dv/tb_ex_unit.sv

/* dv/tb_ex_unit.sv */
`timescale 1ns/1ns

module tb_ex_unit import ex_op_pkg::*; ();

    localparam int XLEN = 64;
    localparam logic [XLEN-1:0] ONES = {XLEN{1'b1}};

    logic            clk;
    logic            arst_n;
    logic            issue;
    logic            flush;
    alu_op_e         operate;
    logic [XLEN-1:0] pc;
    logic [XLEN-1:0] rs1;
    logic [XLEN-1:0] rs2;
    logic [XLEN-1:0] csr;
    logic [XLEN-1:0] imm;
    sel_a_e          sel_a;
    sel_b_e          sel_b;
    logic            word;
    logic [XLEN-1:0] res;
    logic            busy;

    logic [XLEN-1:0] ref_val;
    logic [XLEN-1:0] exp_mul;
    logic [XLEN-1:0] res_before;
    int              run_len;
    integer          seed;

    ex_unit #(.XLEN(XLEN)) dut (
        .clk     (clk),
        .arst_n  (arst_n),
        .issue   (issue),
        .flush   (flush),
        .operate (operate),
        .pc      (pc),
        .rs1     (rs1),
        .rs2     (rs2),
        .csr     (csr),
        .imm     (imm),
        .sel_a   (sel_a),
        .sel_b   (sel_b),
        .word    (word),
        .res     (res),
        .busy    (busy)
    );

    always #50 clk = ~clk;

    function automatic logic [XLEN-1:0] pick_a(input sel_a_e sa, input logic w,
                                               input logic [XLEN-1:0] pc_v,
                                               input logic [XLEN-1:0] rs1_v);
        logic [XLEN-1:0] rs1_w;
        rs1_w = {{(XLEN-32){1'b0}}, rs1_v[31:0]};
        if (sa == sel_a_pc) begin
            return pc_v;
        end
        return w ? rs1_w : rs1_v;
    endfunction

    function automatic logic [XLEN-1:0] pick_b(input sel_b_e sb, input logic [XLEN-1:0] imm_v,
                                               input logic [XLEN-1:0] rs2_v,
                                               input logic [XLEN-1:0] csr_v);
        if (sb == sel_b_rs2) begin
            return rs2_v;
        end else if (sb == sel_b_csr) begin
            return csr_v;
        end
        return imm_v;
    endfunction

    // expected value from the operation rules
    function automatic logic [XLEN-1:0] expected_result(input alu_op_e op,
                                                        input logic [XLEN-1:0] a,
                                                        input logic [XLEN-1:0] b,
                                                        input logic w);
        logic [XLEN-1:0] msb;
        logic [XLEN-1:0] fill;
        logic [31:0]     lo_res;
        logic [5:0]      sh;
        logic            lt_s;
        msb = {1'b1, {(XLEN-1){1'b0}}};
        sh = b[5:0];
        // signed order by flipping the sign bits
        lt_s = (a ^ msb) < (b ^ msb);
        fill = a[XLEN-1] ? ~(ONES >> sh) : '0;
        lo_res = (a[31:0] >> sh) | (a[31] ? ~(32'hffff_ffff >> sh) : 32'h0);
        case (op)
            op_add:   return a + b;
            op_sub:   return a + ~b + 1'b1;
            op_ret_a: return a;
            op_ret_b: return b;
            op_xor:   return a ^ b;
            op_or:    return a | b;
            op_and:   return a & b;
            op_sll:   return a << sh;
            op_srl:   return a >> sh;
            op_sra:   return w ? {{(XLEN-32){1'b0}}, lo_res} : ((a >> sh) | fill);
            op_slt:   return lt_s ? 1 : 0;
            op_sltu:  return (a < b) ? 1 : 0;
            op_eq:    return (a == b) ? 1 : 0;
            op_ge:    return lt_s ? 0 : 1;
            op_geu:   return (a < b) ? 0 : 1;
            op_mul:   return a * b;
            default:  return '0;
        endcase
    endfunction

    assign ref_val = expected_result(operate, pick_a(sel_a, word, pc, rs1),
                                     pick_b(sel_b, imm, rs2, csr), word);

    // length of the current busy run in cycles
    always @(posedge clk) begin
        if (!busy) begin
            run_len <= 0;
        end else begin
            run_len <= run_len + 1;
        end
    end

    task automatic stop_run(input string line);
        $display("%s", line);
        $display("** FAIL **");
        $fatal(1, "simulation stopped on the first error");
    endtask

    reset_clear_a: assert property (
        @(posedge clk) $rose(arst_n) |-> (!busy && res == '0)
    ) else stop_run($sformatf("Fail %0t: after reset busy=%b res=%h", $time, busy, res));

    single_result_a: assert property (
        @(posedge clk) disable iff (!arst_n)
        (issue && !busy && operate != op_mul) |=> (res == $past(ref_val))
    ) else stop_run($sformatf("Fail %0t: single-cycle result %h is wrong", $time, res));

    mul_busy_rise_a: assert property (
        @(posedge clk) disable iff (!arst_n)
        (issue && !busy && operate == op_mul) |=> busy
    ) else stop_run($sformatf("Fail %0t: busy did not rise on a multiply", $time));

    mul_length_a: assert property (
        @(posedge clk) disable iff (!arst_n)
        ($fell(busy) && !$past(flush)) |-> (run_len == XLEN)
    ) else stop_run($sformatf("Fail %0t: busy was high for %0d cycles", $time, run_len));

    mul_product_a: assert property (
        @(posedge clk) disable iff (!arst_n)
        ($fell(busy) && !$past(flush)) |-> (res == exp_mul)
    ) else stop_run($sformatf("Fail %0t: product %h, expected %h", $time, res, exp_mul));

    busy_issue_ignored_a: assert property (
        @(posedge clk) disable iff (!arst_n)
        (issue && busy) |=> busy
    ) else stop_run($sformatf("Fail %0t: issue while busy ended the multiply", $time));

    flush_abort_a: assert property (
        @(posedge clk) disable iff (!arst_n)
        (flush && busy) |=> (!busy && res == res_before)
    ) else stop_run($sformatf("Fail %0t: flush left busy=%b res=%h", $time, busy, res));

    task automatic next_cycle();
        @(posedge clk);
        #1;
    endtask

    function automatic logic [XLEN-1:0] rand_word();
        logic [31:0] hi;
        logic [31:0] lo;
        hi = $random(seed);
        lo = $random(seed);
        return XLEN'({hi, lo});
    endfunction

    // same value everywhere hits the equal cases of the compares
    task automatic randomize_operands(input bit same);
        pc = rand_word();
        rs1 = same ? pc : rand_word();
        rs2 = same ? pc : rand_word();
        csr = same ? pc : rand_word();
        imm = same ? pc : rand_word();
    endtask

    task automatic issue_single(input alu_op_e op, input sel_a_e sa, input sel_b_e sb,
                                input logic w);
        operate = op;
        sel_a = sa;
        sel_b = sb;
        word = w;
        issue = 1'b1;
        next_cycle();
        issue = 1'b0;
    endtask

    task automatic start_multiply(input logic [XLEN-1:0] a_val, input logic [XLEN-1:0] b_val);
        operate = op_mul;
        sel_a = sel_a_rs1;
        sel_b = sel_b_rs2;
        word = 1'b0;
        rs1 = a_val;
        rs2 = b_val;
        exp_mul = expected_result(op_mul, a_val, b_val, 1'b0);
        issue = 1'b1;
        next_cycle();
        issue = 1'b0;
    endtask

    // one extra edge so the checks on the falling edge of busy run
    task automatic wait_idle(input int limit);
        int n;
        n = 0;
        while (busy) begin
            if (n == limit) begin
                stop_run("timeout: busy never dropped after a multiply");
            end
            next_cycle();
            n++;
        end
        next_cycle();
    endtask

    initial begin
        alu_op_e op;
        seed = 8;
        clk = 1'b0;
        arst_n = 1'b0;
        issue = 1'b0;
        flush = 1'b0;
        operate = op_add;
        pc = '0;
        rs1 = '0;
        rs2 = '0;
        csr = '0;
        imm = '0;
        sel_a = sel_a_pc;
        sel_b = sel_b_imm;
        word = 1'b0;
        exp_mul = '0;
        res_before = '0;
        repeat (5) @(posedge clk);
        #1;
        arst_n = 1'b1;
        next_cycle();

        // every single-cycle op over every operand source and word mode
        for (int round = 0; round < 3; round++) begin
            for (int i = 0; i < 20; i++) begin
                op = alu_op_e'(i);
                if (op == op_mul) begin
                    continue;
                end
                for (int sa = 0; sa < 2; sa++) begin
                    for (int sb = 0; sb < 3; sb++) begin
                        for (int w = 0; w < 2; w++) begin
                            randomize_operands(round == 1);
                            issue_single(op, sel_a_e'(sa), sel_b_e'(sb), w[0]);
                        end
                    end
                end
            end
        end

        // multiply with edge operands
        start_multiply('0, rand_word());
        wait_idle(XLEN + 4);
        start_multiply(rand_word(), '0);
        wait_idle(XLEN + 4);
        start_multiply(ONES, ONES);
        wait_idle(XLEN + 4);
        repeat (3) begin
            start_multiply(rand_word(), rand_word());
            wait_idle(XLEN + 4);
        end

        // issue in the middle of a run is ignored
        start_multiply(rand_word(), rand_word());
        repeat (10) next_cycle();
        issue = 1'b1;
        next_cycle();
        issue = 1'b0;
        wait_idle(XLEN + 4);

        // flush after a single-cycle result
        randomize_operands(1'b0);
        res_before = expected_result(op_xor, rs1, rs2, 1'b0);
        issue_single(op_xor, sel_a_rs1, sel_b_rs2, 1'b0);
        start_multiply(rand_word(), rand_word());
        repeat (20) next_cycle();
        flush = 1'b1;
        next_cycle();
        flush = 1'b0;
        wait_idle(XLEN + 4);

        // next multiply after the abort
        start_multiply(rand_word(), rand_word());
        wait_idle(XLEN + 4);

        repeat (2) next_cycle();
        $display("** PASS **");
        $finish;
    end

endmodule

/* hw/alu_core.sv */
`timescale 1ns/1ns

module alu_core import ex_op_pkg::*; #(
    parameter int XLEN = 64
) (
    input  logic            clk,
    input  logic            arst_n,
    input  logic            issue,
    input  alu_op_e         operate,
    input  logic [XLEN-1:0] pc,
    input  logic [XLEN-1:0] rs1,
    input  logic [XLEN-1:0] rs2,
    input  logic [XLEN-1:0] csr,
    input  logic [XLEN-1:0] imm,
    input  sel_a_e          sel_a,
    input  sel_b_e          sel_b,
    input  logic            word,
    output logic [XLEN-1:0] a_op,
    output logic [XLEN-1:0] b_op,
    output logic [XLEN-1:0] alu_res
);

    logic [XLEN-1:0] rs1_sel;
    logic [XLEN-1:0] alu_val;
    logic [31:0]     sra_w;
    shamt_t          shamt;

    // word mode keeps only the low 32 bits of rs1
    assign rs1_sel = word ? XLEN'(rs1[31:0]) : rs1;

    assign a_op = (sel_a == sel_a_rs1) ? rs1_sel : pc;

    always_comb begin
        case (sel_b)
            sel_b_rs2: b_op = rs2;
            sel_b_csr: b_op = csr;
            default:   b_op = imm;
        endcase
    end

    assign shamt = shamt_t'(b_op);

    // 32-bit arithmetic shift for word mode
    assign sra_w = 32'($signed(a_op[31:0]) >>> shamt);

    always_comb begin
        alu_val = '0;
        case (operate)
            op_add: begin
                alu_val = a_op + b_op;
            end
            op_sub: begin
                alu_val = a_op - b_op;
            end
            op_ret_a: alu_val = a_op;
            op_ret_b: alu_val = b_op;
            op_xor:   alu_val = a_op ^ b_op;
            op_or:    alu_val = a_op | b_op;
            op_and:   alu_val = a_op & b_op;
            op_sll:   alu_val = a_op << shamt;
            op_srl:   alu_val = a_op >> shamt;
            op_sra: begin
                if (word) begin
                    alu_val = XLEN'(sra_w);
                end else begin
                    alu_val = XLEN'($signed(a_op) >>> shamt);
                end
            end
            // compares return 0 or 1
            op_slt:  alu_val = XLEN'($signed(a_op) < $signed(b_op));
            op_sltu: alu_val = XLEN'(a_op < b_op);
            op_eq:   alu_val = XLEN'(a_op == b_op);
            op_ge:   alu_val = XLEN'($signed(a_op) >= $signed(b_op));
            op_geu:  alu_val = XLEN'(a_op >= b_op);
            // mul runs in the sequential unit, division is not built
            default: alu_val = '0;
        endcase
    end

    // a multiply issue leaves the last single-cycle result in place
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            alu_res <= '0;
        end else if (issue && (operate != op_mul)) begin
            alu_res <= alu_val;
        end
    end

    // operand b mux has no fourth source
    sel_b_legal_a: assert property (
        @(posedge clk) disable iff (!arst_n)
        issue |-> (sel_b != sel_b_e'(2'b11))
    ) else $error("sel_b uses the unused encoding");

endmodule

/* hw/ex_ctrl_pkg.sv */
package ex_ctrl_pkg;

    // sequential multiplier states
    // st_run covers all iterations, including the final one
    typedef enum logic [1:0] {
        st_idle = 2'd0,
        st_run  = 2'd1
    } mul_state_e;

endpackage

/* hw/ex_op_pkg.sv */
package ex_op_pkg;

    // operation code seen by the execute stage
    typedef enum logic [4:0] {
        op_add,
        op_sub,
        op_ret_a,
        op_ret_b,
        op_xor,
        op_or,
        op_and,
        op_sll,
        op_srl,
        op_sra,
        op_slt,
        op_sltu,
        op_eq,
        op_ge,
        op_geu,
        op_mul,
        op_div,
        op_divu,
        op_rem,
        op_remu
    } alu_op_e;

    // operand a source
    typedef enum logic [1:0] {
        sel_a_pc  = 2'd0,
        sel_a_rs1 = 2'd1
    } sel_a_e;

    // operand b source, encoding 3 is unused
    typedef enum logic [1:0] {
        sel_b_imm = 2'd0,
        sel_b_rs2 = 2'd1,
        sel_b_csr = 2'd2
    } sel_b_e;

    // shift amount from the low bits of operand b
    typedef logic [5:0] shamt_t;

endpackage

/* hw/ex_unit.sv */
`timescale 1ns/1ns

module ex_unit import ex_op_pkg::*; #(
    parameter int XLEN = 64
) (
    input  logic            clk,
    input  logic            arst_n,
    input  logic            issue,
    input  logic            flush,
    input  alu_op_e         operate,
    input  logic [XLEN-1:0] pc,
    input  logic [XLEN-1:0] rs1,
    input  logic [XLEN-1:0] rs2,
    input  logic [XLEN-1:0] csr,
    input  logic [XLEN-1:0] imm,
    input  sel_a_e          sel_a,
    input  sel_b_e          sel_b,
    input  logic            word,
    output logic [XLEN-1:0] res,
    output logic            busy
);

    logic [XLEN-1:0] a_op;
    logic [XLEN-1:0] b_op;
    logic [XLEN-1:0] alu_res;
    logic [XLEN-1:0] product;
    logic [XLEN-1:0] mul_res_q;
    logic            res_is_mul_q;
    logic            single_issue;

    mul_if mif ();

    alu_core #(.XLEN(XLEN)) u_alu_core (
        .clk     (clk),
        .arst_n  (arst_n),
        .issue   (issue),
        .operate (operate),
        .pc      (pc),
        .rs1     (rs1),
        .rs2     (rs2),
        .csr     (csr),
        .imm     (imm),
        .sel_a   (sel_a),
        .sel_b   (sel_b),
        .word    (word),
        .a_op    (a_op),
        .b_op    (b_op),
        .alu_res (alu_res)
    );

    mul_ctrl u_mul_ctrl (
        .clk     (clk),
        .arst_n  (arst_n),
        .issue   (issue),
        .flush   (flush),
        .operate (operate),
        .busy    (busy),
        .mif     (mif.ctrl)
    );

    mul_counter #(.XLEN(XLEN)) u_mul_counter (
        .clk    (clk),
        .arst_n (arst_n),
        .mif    (mif.cnt)
    );

    mul_datapath #(.XLEN(XLEN)) u_mul_datapath (
        .clk     (clk),
        .arst_n  (arst_n),
        .a_op    (a_op),
        .b_op    (b_op),
        .mif     (mif.dp),
        .product (product)
    );

    assign single_issue = issue && !busy && (operate != op_mul);

    // finished product
    always_ff @(posedge clk) begin
        if (mif.done) begin
            mul_res_q <= product;
        end
    end

    // tracks which unit wrote the result last
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            res_is_mul_q <= 1'b0;
        end else if (mif.done) begin
            res_is_mul_q <= 1'b1;
        end else if (single_issue) begin
            res_is_mul_q <= 1'b0;
        end
    end

    assign res = res_is_mul_q ? mul_res_q : alu_res;

endmodule

/* hw/mul_counter.sv */
`timescale 1ns/1ns

module mul_counter #(
    parameter int XLEN = 64
) (
    input logic clk,
    input logic arst_n,
    mul_if.cnt  mif
);

    localparam int CW = $clog2(XLEN);

    logic [CW-1:0] count_q;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            count_q <= '0;
        end else if (mif.load) begin
            count_q <= '0;
        end else if (mif.step) begin
            count_q <= count_q + 1'b1;
        end
    end

    // final iteration of XLEN
    assign mif.last = (count_q == CW'(XLEN - 1));

    // controller must stop stepping after the final iteration
    no_step_past_last_a: assert property (
        @(posedge clk) disable iff (!arst_n)
        (mif.step && mif.last) |=> !mif.step
    ) else $error("step after the last multiply iteration");

endmodule

/* hw/mul_ctrl.sv */
`timescale 1ns/1ns

module mul_ctrl import ex_op_pkg::*, ex_ctrl_pkg::*; (
    input  logic    clk,
    input  logic    arst_n,
    input  logic    issue,
    input  logic    flush,
    input  alu_op_e operate,
    output logic    busy,
    mul_if.ctrl     mif
);

    mul_state_e state_q;
    mul_state_e state_d;
    logic       start;

    // new multiply accepted only when idle
    assign start = (state_q == st_idle) && issue && (operate == op_mul);

    always_comb begin
        state_d = state_q;
        case (state_q)
            st_idle: begin
                if (start) begin
                    state_d = st_run;
                end
            end
            st_run: begin
                // flush aborts and last ends normally
                if (flush || mif.last) begin
                    state_d = st_idle;
                end
            end
            default: state_d = st_idle;
        endcase
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            state_q <= st_idle;
        end else begin
            state_q <= state_d;
        end
    end

    assign mif.load = start;
    assign mif.step = (state_q == st_run);

    // no done pulse on an aborted multiply
    assign mif.done = (state_q == st_run) && mif.last && !flush;

    assign busy = (state_q == st_run);

    // counter restarts on load so done cannot come in the first run cycle
    done_not_first_a: assert property (
        @(posedge clk) disable iff (!arst_n)
        mif.load |=> !mif.done
    ) else $error("done on the first cycle of a multiply");

endmodule

/* hw/mul_datapath.sv */
`timescale 1ns/1ns

module mul_datapath #(
    parameter int XLEN = 64
) (
    input  logic            clk,
    input  logic            arst_n,
    input  logic [XLEN-1:0] a_op,
    input  logic [XLEN-1:0] b_op,
    mul_if.dp               mif,
    output logic [XLEN-1:0] product
);

    logic [XLEN-1:0] mcand_q;
    logic [XLEN-1:0] mplier_q;
    logic [XLEN-1:0] acc_q;
    logic [XLEN-1:0] acc_sum;

    // partial sum including the current multiplier bit
    assign acc_sum = acc_q + (mplier_q[0] ? mcand_q : '0);

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            mcand_q  <= '0;
            mplier_q <= '0;
            acc_q    <= '0;
        end else if (mif.load) begin
            mcand_q  <= a_op;
            mplier_q <= b_op;
            acc_q    <= '0;
        end else if (mif.step && !mif.done) begin
            acc_q    <= acc_sum;
            mcand_q  <= mcand_q << 1;
            mplier_q <= mplier_q >> 1;
        end
    end

    // final bit is added on the done cycle straight from the adder,
    // registers then freeze so the product stays valid until the next load
    assign product = acc_sum;

endmodule

/* hw/mul_if.sv */
`timescale 1ns/1ns

interface mul_if;

    // start of a multiply, clears counter and accumulator
    logic load;
    // one shift-and-add iteration
    logic step;
    // counter sits on the final iteration
    logic last;
    // product is complete this cycle
    logic done;

    modport ctrl (
        output load,
        output step,
        output done,
        input  last
    );

    modport cnt (
        input  load,
        input  step,
        output last
    );

    modport dp (
        input load,
        input step,
        input done
    );

endinterface

/* list.f */
hw/ex_op_pkg.sv
hw/ex_ctrl_pkg.sv
hw/mul_if.sv
hw/alu_core.sv
hw/mul_ctrl.sv
hw/mul_counter.sv
hw/mul_datapath.sv
hw/ex_unit.sv
dv/tb_ex_unit.sv
